//--- project.f
rtl/pixelPkg.sv
rtl/logMathPkg.sv
rtl/logEncoder.sv
rtl/logDecoder.sv
rtl/logMultiplier.sv
rtl/descriptorLoader.sv
rtl/correlationAccumulator.sv
rtl/patchCorrelator.sv
testbench/patchCorrelatorTb.sv

//--- rtl/correlationAccumulator.sv
`default_nettype none

// Adds up the signed products of a patch and offers the sum as a score
module correlationAccumulator import pixelPkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    prodValid,
	input  productT product,
	input  logic    prodLast,
	output logic    accReady,
	output scoreT   score,
	output logic    scoreValid,
	input  logic    scoreReady
);

	scoreT runSum; // Sum of the products seen so far in the current patch
	scoreT nextSum;
	logic prodAccept;

	// Ready when the score register is empty or is handed over in this cycle
	assign accReady = !scoreValid || scoreReady;
	assign prodAccept = prodValid && accReady;

	assign nextSum = runSum + scoreT'(product); // Product is sign-extended to the score width

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			runSum <= '0;
			scoreValid <= 1'b0;
		end else begin
			if (prodAccept && prodLast) begin
				runSum <= '0; // Next patch starts from nothing
				scoreValid <= 1'b1;
			end else begin
				if (prodAccept) runSum <= nextSum;
				if (scoreReady) scoreValid <= 1'b0; // Host took the score
			end
		end
	end

	// The last product completes the patch and the total goes straight to the output
	always_ff @(posedge clk) begin
		if (prodAccept && prodLast) begin
			score <= nextSum;
		end
	end

	// A score that waits on the host must neither vanish nor change
	assert property (@(posedge clk) disable iff (rst)
		(scoreValid && !scoreReady) |=> (scoreValid && $stable(score)));

endmodule : correlationAccumulator

`default_nettype wire

//--- rtl/descriptorLoader.sv
`default_nettype none

// Loads a descriptor from the host and pairs it byte for byte with streamed patch pixels
module descriptorLoader import pixelPkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  pixelT     descByte,
	input  logic      descValid,
	output logic      descReady,
	input  pixelT     pixel,
	input  logic      pixelValid,
	output logic      pixelReady,
	input  logic      pairReady,
	output logic      pairValid,
	output pixelT     pairPixel,
	output descPixelT pairDesc,
	output logic      pairLast
);

	typedef enum logic [1:0] {EMPTY, LOADING, READY} loadStateT;

	loadStateT state, nextState;
	descPixelT descReg [PATCH_PIXELS]; // Entry 0 is the head that meets the current pixel
	posT byteCount; // Bytes taken in the current load
	posT pixelPos; // Pixel position inside the patch
	logic byteAccept, pixelAccept;
	logic descTakesBus; // A reload waiting at a patch boundary wins over pixels
	logic streamOpen;

	// Outside of READY a load may always go on, inside it only between patches
	assign descReady = (state != READY) || (pixelPos == '0);
	assign byteAccept = descValid && descReady;

	assign descTakesBus = descValid && (pixelPos == '0);
	assign streamOpen = (state == READY) && !descTakesBus;
	assign pixelReady = streamOpen && pairReady;
	assign pixelAccept = pixelValid && pixelReady;

	// The pair is formed combinationally so an accepted pixel enters the multiplier at once
	assign pairValid = streamOpen && pixelValid;
	assign pairPixel = pixel;
	assign pairDesc = descReg[0];
	assign pairLast = (pixelPos == posT'(PATCH_PIXELS - 1));

	always_comb begin
		nextState = state;
		case (state)
			EMPTY: if (byteAccept) nextState = LOADING;
			LOADING: begin
				if (byteAccept && byteCount == posT'(PATCH_PIXELS - 1)) begin
					nextState = READY; // Sixteenth byte just arrived
				end
			end
			READY: if (byteAccept) nextState = LOADING; // Reload starts on a patch boundary
			default: nextState = EMPTY;
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= EMPTY;
			byteCount <= '0;
			pixelPos <= '0;
		end else begin
			state <= nextState;
			if (byteAccept) byteCount <= byteCount + 1'b1; // Wraps to 0 at the end of a load
			if (pixelAccept) pixelPos <= pixelPos + 1'b1; // Wraps to 0 after the last pixel
		end
	end

	// Loading and rotation share one shift toward the head
	// A new byte enters at the tail during a load, the head comes around during a patch
	always_ff @(posedge clk) begin
		if (byteAccept || pixelAccept) begin
			for (int i = 0; i < PATCH_PIXELS - 1; i++) begin
				descReg[i] <= descReg[i+1];
			end
			descReg[PATCH_PIXELS-1] <= byteAccept ? descPixelT'(descByte) : descReg[0];
		end
	end

	// Once a load is under way no pixel may be taken until its last byte is in
	assert property (@(posedge clk) disable iff (rst)
		(byteAccept && byteCount != posT'(PATCH_PIXELS - 1)) |=> !pixelAccept);

endmodule : descriptorLoader

`default_nettype wire

//--- rtl/logDecoder.sv
`default_nettype none

// Inverse log2 that rebuilds a product magnitude from a Mitchell log sum
module logDecoder import logMathPkg::*; (
	input  logSumT     logSum,
	output magProductT mag
);

	logic [LOG_INT_BITS:0] intPart; // Exponent n of the sum
	logic [FRAC_BITS-1:0]  fracPart; // Fraction f of the sum
	magProductT powerTerm;

	// The fraction is shifted by n before the binary point is applied
	logic [2*MAG_WIDTH+FRAC_BITS-1:0] fracScaled;

	assign intPart  = logSum[LOG_INT_BITS+FRAC_BITS -: LOG_INT_BITS+1];
	assign fracPart = logSum[FRAC_BITS-1:0];

	assign powerTerm = magProductT'(1) << intPart; // The leading bit 2^n

	// f * 2^n still carries FRAC_BITS bits below the integer point
	assign fracScaled = {{(2*MAG_WIDTH){1'b0}}, fracPart} << intPart;

	// Bits below the integer point are cut off, which truncates toward zero
	// The fraction part is always below 2^n so it slots in under the leading bit
	assign mag = powerTerm | fracScaled[2*MAG_WIDTH+FRAC_BITS-1:FRAC_BITS];

endmodule : logDecoder

`default_nettype wire

//--- rtl/logEncoder.sv
`default_nettype none

// Finds the leading one of a magnitude and turns it into a Mitchell log2 value
module logEncoder import logMathPkg::*; (
	input  magT    mag,
	output logic   isZero,
	output logValT logVal
);

	logic [LOG_INT_BITS-1:0] zeroCount; // Leading zeros found by the search
	logic [LOG_INT_BITS-1:0] leadIdx;
	magT normMag; // Magnitude shifted so the leading one sits in the top bit

	// Binary search in halving steps, first four bits, then two, then one
	always_comb begin
		zeroCount = '0;
		normMag = mag;
		if (normMag[MAG_WIDTH-1 -: 4] == 4'd0) begin
			normMag = normMag << 4;
			zeroCount[2] = 1'b1; // Upper half was empty
		end
		if (normMag[MAG_WIDTH-1 -: 2] == 2'd0) begin
			normMag = normMag << 2;
			zeroCount[1] = 1'b1;
		end
		if (!normMag[MAG_WIDTH-1]) begin
			normMag = normMag << 1;
			zeroCount[0] = 1'b1; // Last single step
		end
	end

	// A zero input ends with seven leading zeros and must be flagged separately
	assign isZero = (mag == '0);

	assign leadIdx = LOG_INT_BITS'(MAG_WIDTH - 1) - zeroCount; // Position k of the leading one

	// Drop the leading one and left-align what remains as the fraction
	// With 8 fraction bits the seven remaining bits always fit so nothing is lost here
	assign logVal = {leadIdx, normMag[MAG_WIDTH-2:0], {(FRAC_BITS - MAG_WIDTH + 1){1'b0}}};

endmodule : logEncoder

`default_nettype wire

//--- rtl/logMathPkg.sv
`default_nettype none

// Fixed-point formats of the Mitchell log-domain multiplier
// Encoding takes the leading one position k of x as the integer part of log2(x)
// The bits below the leading one are left-aligned into FRAC_BITS fraction bits
// Fraction bits beyond FRAC_BITS are truncated
// Decoding turns integer part n and fraction f into 2^n + f * 2^n, truncated toward zero
// A zero on either side gives a product of 0
// The sign of the product is the sign of the descriptor byte
package logMathPkg;

	localparam int MAG_WIDTH = 8; // Width of a magnitude fed to the encoder
	localparam int FRAC_BITS = 8; // Fraction bits of a log value
	localparam int LOG_INT_BITS = $clog2(MAG_WIDTH); // Integer part holds 0 to 7

	typedef logic [MAG_WIDTH-1:0] magT;

	typedef logic [LOG_INT_BITS+FRAC_BITS-1:0] logValT; // 3.8 fixed point

	typedef logic [LOG_INT_BITS+FRAC_BITS:0] logSumT; // Sum of two logs needs one more bit

	typedef logic [2*MAG_WIDTH-1:0] magProductT; // Decoded product magnitude

endpackage : logMathPkg

`default_nettype wire

//--- rtl/logMultiplier.sv
`default_nettype none

// Three-stage signed multiplier working in the log domain
module logMultiplier import pixelPkg::*, logMathPkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      inValid,
	input  pixelT     inPixel,
	input  descPixelT inDesc,
	input  logic      inLast,
	input  logic      outReady,
	output logic      inReady,
	output logic      outValid,
	output productT   product,
	output logic      outLast
);

	logic advance; // Every stage moves forward together
	magT descMag; // Absolute value of the descriptor byte
	logic pixZero, descZero;
	logValT pixLog, descLog;
	magProductT decMag;
	productT magSigned;

	logic valid1, zero1, neg1, last1; // Stage 1 registers
	logValT pixLog1, descLog1;
	logic valid2, zero2, neg2, last2; // Stage 2 registers
	logSumT logSum2;

	assign advance = outReady;
	assign inReady = outReady; // A stalled output stalls the whole pipe

	// The absolute value of -128 still fits as 128 in the unsigned magnitude
	assign descMag = inDesc[7] ? magT'(-inDesc) : magT'(inDesc);

	logEncoder pixEnc_i (.mag(inPixel), .isZero(pixZero), .logVal(pixLog));
	logEncoder descEnc_i (.mag(descMag), .isZero(descZero), .logVal(descLog));
	logDecoder dec_i (.logSum(logSum2), .mag(decMag));

	assign magSigned = productT'({1'b0, decMag}); // Magnitude is at most 15 bits wide

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			outValid <= 1'b0;
		end else if (advance) begin
			valid1 <= inValid;
			valid2 <= valid1;
			outValid <= valid2;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			pixLog1 <= pixLog; // Stage 1 holds the two encoded magnitudes
			descLog1 <= descLog;
			zero1 <= pixZero | descZero;
			neg1 <= inDesc[7]; // Pixels are unsigned so only the descriptor sets the sign
			last1 <= inLast;
			logSum2 <= logSumT'(pixLog1) + logSumT'(descLog1); // Multiply becomes add
			zero2 <= zero1;
			neg2 <= neg1;
			last2 <= last1;
			if (zero2) begin
				product <= '0; // A zero operand has no log so the decoder output is ignored
			end else begin
				product <= neg2 ? -magSigned : magSigned;
			end
			outLast <= last2;
		end
	end

	// A zero pixel or a zero descriptor byte that runs through all three stages comes out as 0
	assert property (@(posedge clk) disable iff (rst)
		(advance && inValid && (inPixel == '0 || inDesc == '0)) ##1 advance ##1 advance
		|=> (outValid && product == '0));

endmodule : logMultiplier

`default_nettype wire

//--- rtl/patchCorrelator.sv
`default_nettype none

// Correlates streamed image patches against a loaded descriptor
module patchCorrelator import pixelPkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  pixelT descByte,
	input  logic  descValid,
	output logic  descReady,
	input  pixelT pixel,
	input  logic  pixelValid,
	output logic  pixelReady,
	output scoreT score,
	output logic  scoreValid,
	input  logic  scoreReady
);

	// Loader to multiplier
	logic pairValid, pairLast, multReady;
	pixelT pairPixel;
	descPixelT pairDesc;

	// Multiplier to accumulator
	logic prodValid, prodLast, accReady;
	productT product;

	descriptorLoader loader_i (
		.clk(clk),
		.rst(rst),
		.descByte(descByte),
		.descValid(descValid),
		.descReady(descReady),
		.pixel(pixel),
		.pixelValid(pixelValid),
		.pixelReady(pixelReady),
		.pairReady(multReady),
		.pairValid(pairValid),
		.pairPixel(pairPixel),
		.pairDesc(pairDesc),
		.pairLast(pairLast)
	);

	// The patch end marker rides along with each product
	logMultiplier mult_i (
		.clk(clk),
		.rst(rst),
		.inValid(pairValid),
		.inPixel(pairPixel),
		.inDesc(pairDesc),
		.inLast(pairLast),
		.outReady(accReady),
		.inReady(multReady),
		.outValid(prodValid),
		.product(product),
		.outLast(prodLast)
	);

	correlationAccumulator acc_i (
		.clk(clk),
		.rst(rst),
		.prodValid(prodValid),
		.product(product),
		.prodLast(prodLast),
		.accReady(accReady),
		.score(score),
		.scoreValid(scoreValid),
		.scoreReady(scoreReady)
	);

endmodule : patchCorrelator

`default_nettype wire

//--- rtl/pixelPkg.sv
`default_nettype none

// Types shared by the patch streams and the score path
package pixelPkg;

	// One descriptor and one patch both hold this many pixels
	localparam int PATCH_PIXELS = 16;

	// Width of the patch position and descriptor byte counters
	localparam int POS_WIDTH = $clog2(PATCH_PIXELS);

	typedef logic [7:0] pixelT; // Unsigned image pixel as it arrives from the host

	typedef logic signed [7:0] descPixelT; // Zero-mean descriptor byte

	// A pixel times a descriptor byte fits in 17 bits with sign
	typedef logic signed [16:0] productT;

	// Sixteen products summed need four more bits than one product
	typedef logic signed [23:0] scoreT;

	typedef logic [POS_WIDTH-1:0] posT; // Position inside a patch or a descriptor load

endpackage : pixelPkg

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module patchCorrelatorTb &&
./obj_dir/VpatchCorrelatorTb | tee /dev/stderr | grep -q "^TESTS PASSED$" ||
{ echo "Simulation failed"; exit 1; }

//--- testbench/correlatorTrace.txt
# D: tag, then 16 descriptor bytes in hex as signed two's complement, byte 0 first
# P: tag, then 16 pixels in hex, pixel 0 first, then the expected score as 24-bit hex
# Descriptor of signed powers of two, every product against it is exact
D 01 ff 02 fe 04 fc 08 f8 10 f0 20 e0 40 c0 00 00
# Dark patch, all products are zero
P 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 000000
# Mixed pixels, zero and full scale among them, score -21113
P c8 03 64 07 32 00 19 ff 0c 01 06 80 03 ff 63 4d ffad87
# Ramp in steps of 16, score -2032
P 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 fff810
# Bright where the bytes are positive, dark where they are negative, 255 * 127
P ff 00 ff 00 ff 00 ff 00 ff 00 ff 00 ff 00 ff 00 007e81
# Reload with general bytes, where the Mitchell error shows
D 80 7f 03 fd 05 fb 06 fa 0a f6 64 9c 00 00 01 00
# Mixed pixels, score -58021
P ff 03 03 05 06 07 64 c8 09 00 01 ff ff 00 4d c8 ff1d5b
# Power of two pixels stay exact, 64 * 128
P 00 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 002000
# Saturated patch, the byte pairs almost cancel and leave -1
P ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ffffff
P ff 03 03 05 06 07 64 c8 09 00 01 ff ff 00 4d c8 ff1d5b
# Back to the power of two descriptor
D 01 ff 02 fe 04 fc 08 f8 10 f0 20 e0 40 c0 00 00
P c8 03 64 07 32 00 19 ff 0c 01 06 80 03 ff 63 4d ffad87
P 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 fff810
P 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 000000

//--- testbench/patchCorrelatorTb.sv
`default_nettype none

// Trace driven testbench for the patch correlator
module patchCorrelatorTb import pixelPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 1000; // Longest any single wait may last, in cycles

	logic clk = 1'b0;
	logic rst;
	pixelT descByte, pixel;
	logic descValid, descReady, pixelValid, pixelReady;
	scoreT score;
	logic scoreValid, scoreReady;

	bit isPatch [$]; // Record kinds in trace order
	pixelT recBytes [$]; // Sixteen bytes for every record
	scoreT traceScores [$]; // Expected score of every patch record
	scoreT expectQ [$]; // Patches sent whose score has not come out yet
	scoreT expected;
	int errorCount = 0;
	int checkCount = 0;
	int patchCount = 0;
	int scoreCount = 0;
	int seed = 32'hfcb03154;

	always #2 clk = ~clk; // 4 ns period

	patchCorrelator dut_i (.*);

	task automatic reportMismatch(input string name, input logic [23:0] got,
			input logic [23:0] exp);
		$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		errorCount++;
	endtask

	task automatic finishRun();
		$display("Checks %0d, errors %0d, patches %0d, scores %0d",
			checkCount, errorCount, patchCount, scoreCount);
		if (errorCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	task automatic abortOnTimeout(input string what);
		$display("Timeout after %0d cycles: %s", WAIT_LIMIT, what);
		errorCount++;
		finishRun();
	endtask

	// Records start with a tag character, a hash starts a comment line
	task automatic readTrace();
		int fd;
		int code;
		logic [7:0] ch;
		logic [8*160-1:0] rest;
		pixelT value;
		scoreT expScore;
		fd = $fopen("testbench/correlatorTrace.txt", "r");
		if (fd == 0) begin
			$display("The trace file could not be opened");
			errorCount++;
		end else begin
			code = $fscanf(fd, "%c", ch);
			while (code == 1) begin
				if (ch == "#") begin
					code = $fgets(rest, fd); // Skip to the end of the comment
				end else if (ch == "D" || ch == "P") begin
					isPatch.push_back(ch == "P");
					for (int i = 0; i < PATCH_PIXELS; i++) begin
						code = $fscanf(fd, "%h", value);
						recBytes.push_back(value);
					end
					if (ch == "P") begin
						code = $fscanf(fd, "%h", expScore); // Score closes a patch record
						traceScores.push_back(expScore);
					end
				end else if (ch != 8'h20 && ch != 8'h0a && ch != 8'h0d && ch != 8'h09) begin
					$display("The trace holds an unknown record tag %h", ch);
					errorCount++;
				end
				code = $fscanf(fd, "%c", ch);
			end
			$fclose(fd);
		end
	endtask

	// Entered one step after a rising edge and left the same way
	// A pause holds descValid low for one cycle in the middle of a load
	task automatic sendDescByte(input pixelT value, input bit pauseFirst);
		int waited;
		if (pauseFirst) begin
			@(negedge clk);
			checkCount++; // The load is still open so pixels stay shut out
			if (pixelReady !== 1'b0) reportMismatch("pixelReady", 24'(pixelReady), 24'(0));
			@(posedge clk);
			#1;
		end
		descByte = value;
		descValid = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!descReady && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		if (!descReady) begin
			abortOnTimeout("descReady stayed low while a descriptor byte was offered");
		end else begin
			checkCount++; // Pixels stay locked out until the sixteenth byte is in
			if (pixelReady !== 1'b0) reportMismatch("pixelReady", 24'(pixelReady), 24'(0));
			@(posedge clk);
			#1;
			descValid = 1'b0;
		end
	endtask

	task automatic sendPixel(input pixelT value, input bit firstOfPatch);
		int waited;
		pixel = value;
		pixelValid = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!pixelReady && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		if (!pixelReady) begin
			abortOnTimeout("pixelReady stayed low while a pixel was offered");
		end else begin
			checkCount++; // A reload may only start on a patch boundary
			if (descReady !== firstOfPatch) begin
				reportMismatch("descReady", 24'(descReady), 24'(firstOfPatch));
			end
			@(posedge clk); // The pixel transfers on this edge
			#1;
			pixelValid = 1'b0;
		end
	endtask

	// The score consumer takes a score about three cycles in four
	task automatic driveScoreReady();
		forever begin
			@(posedge clk);
			#1;
			scoreReady = (($random(seed) & 3) != 0);
		end
	endtask

	task automatic monitorScores();
		forever begin
			@(negedge clk);
			if (!rst && scoreValid && scoreReady) begin
				scoreCount++;
				if (expectQ.size() == 0) begin
					$display("A score of %h came out with no patch pending", score);
					errorCount++;
				end else begin
					expected = expectQ.pop_front(); // Oldest patch in flight
					checkCount++;
					if (score !== expected) reportMismatch("score", score, expected);
				end
			end
		end
	endtask

	initial begin
		int byteIdx;
		int scoreIdx;
		int waited;
		rst = 1'b1;
		descByte = '0;
		descValid = 1'b0;
		pixel = '0;
		pixelValid = 1'b0;
		scoreReady = 1'b0;
		byteIdx = 0;
		scoreIdx = 0;
		waited = 0;
		readTrace();
		fork
			driveScoreReady();
			monitorScores();
		join_none
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		checkCount += 3;
		if (descReady !== 1'b1) reportMismatch("descReady", 24'(descReady), 24'(1));
		if (pixelReady !== 1'b0) reportMismatch("pixelReady", 24'(pixelReady), 24'(0));
		if (scoreValid !== 1'b0) reportMismatch("scoreValid", 24'(scoreValid), 24'(0));
		@(posedge clk);
		#1;
		foreach (isPatch[r]) begin
			if (isPatch[r]) begin
				expectQ.push_back(traceScores[scoreIdx]); // Queued before its first pixel
				scoreIdx++;
				patchCount++;
				for (int i = 0; i < PATCH_PIXELS; i++) begin
					sendPixel(recBytes[byteIdx + i], i == 0);
				end
			end else begin
				for (int i = 0; i < PATCH_PIXELS; i++) begin
					sendDescByte(recBytes[byteIdx + i], (i % 4) == 3); // Every fourth byte waits
				end
			end
			byteIdx += PATCH_PIXELS;
		end
		while (expectQ.size() != 0 && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		if (expectQ.size() != 0) abortOnTimeout("some scores never came out");
		repeat (10) @(negedge clk); // Gives a duplicated score time to show up
		if (scoreCount != patchCount) begin
			$display("%0d patches were sent but %0d scores came out", patchCount, scoreCount);
			errorCount++;
		end
		finishRun();
	end

endmodule : patchCorrelatorTb

`default_nettype wire
